// ==== rtl/claw_cfg.svh ====
`ifndef CLAW_CFG_SVH
`define CLAW_CFG_SVH

// clock cycles per frame tick
`define CLAW_TICK_CYCLES 16

// rope length limits and step, in pixels
`define CLAW_ROPE_MIN 20
`define CLAW_ROPE_MAX 200
`define CLAW_STEP 12

// rope pivot and playfield size
`define CLAW_ORIGIN_X 160
`define CLAW_ORIGIN_Y 45
`define CLAW_SCREEN_W 320
`define CLAW_SCREEN_H 240

`define CLAW_ITEMS 16

// points per item kind
`define CLAW_SCORE_STONE 10
`define CLAW_SCORE_GOLD 20
`define CLAW_SCORE_DIAMOND 50

`endif

// ==== rtl/claw_geom_pkg.sv ====
package claw_geom_pkg;

    // screen position in pixels
    typedef logic [9:0] coord_t;

    // whole degrees, 90 points straight down
    typedef logic [7:0] angle_t;

    typedef logic [8:0] rope_len_t;

    typedef enum logic [2:0] {
        stop,
        swing_ccw,
        swing_cw,
        extend,
        wait_scan,
        retract
    } rope_state_t;

endpackage

// ==== rtl/claw_item_pkg.sv ====
package claw_item_pkg;

    // x [8:0], y [16:9], kind [18:17], visible [19], carried [20]
    typedef logic [31:0] item_word_t;
    typedef logic [3:0]  item_index_t;
    typedef logic [15:0] score_t;

    typedef enum logic [1:0] {
        stone   = 2'd0,
        gold    = 2'd1,
        diamond = 2'd2
    } item_kind_e;

    localparam int unsigned ITEM_VISIBLE = 19;
    localparam int unsigned ITEM_CARRIED = 20;

    function automatic logic [8:0] item_x(input item_word_t w);
        return w[8:0];
    endfunction

    function automatic logic [7:0] item_y(input item_word_t w);
        return w[16:9];
    endfunction

    function automatic item_kind_e item_kind(input item_word_t w);
        return item_kind_e'(w[18:17]);
    endfunction

endpackage

// ==== rtl/trig_table.sv ====
`timescale 1ns/1ps

module trig_table (
    input  claw_geom_pkg::angle_t angle,
    output logic [8:0]            sin_q,
    output logic [8:0]            cos_q,
    output logic                  cos_neg
);

    logic [7:0] sin_arg;
    logic [7:0] cos_arg;

    // sine every 8 degrees, 8 fraction bits
    // knots past 88 held at 1.0
    function automatic logic [8:0] knot(input logic [3:0] k);
        case (k)
            4'd0:    return 9'd0;
            4'd1:    return 9'd36;
            4'd2:    return 9'd71;
            4'd3:    return 9'd104;
            4'd4:    return 9'd136;
            4'd5:    return 9'd165;
            4'd6:    return 9'd190;
            4'd7:    return 9'd212;
            4'd8:    return 9'd230;
            4'd9:    return 9'd243;
            4'd10:   return 9'd252;
            default: return 9'd256;
        endcase
    endfunction

    // first quadrant, linear between knots
    function automatic logic [8:0] quarter_sin(input logic [6:0] deg);
        logic [8:0]  lo;
        logic [8:0]  hi;
        logic [11:0] span;
        lo   = knot(deg[6:3]);
        hi   = knot(deg[6:3] + 4'd1);
        span = (hi - lo) * deg[2:0];
        return lo + 9'(span >> 3);
    endfunction

    always_comb begin
        cos_neg = angle > 8'd90;
        sin_arg = cos_neg ? 8'd180 - angle : angle;
        // |cos| is the sine of the distance from vertical
        cos_arg = cos_neg ? angle - 8'd90 : 8'd90 - angle;
        sin_q   = quarter_sin(sin_arg[6:0]);
        cos_q   = quarter_sin(cos_arg[6:0]);
    end

endmodule

// ==== rtl/rope_fsm.sv ====
`timescale 1ns/1ps
`include "claw_cfg.svh"

module rope_fsm (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     go,
    input  logic                     scan_done,
    input  logic                     hit,
    input  logic                     release_done,
    output claw_geom_pkg::angle_t    angle,
    output claw_geom_pkg::rope_len_t rope_len,
    output logic                     step_valid,
    output logic                     release_req,
    output logic                     holding
);

    import claw_geom_pkg::*;

    localparam int TICK_W = $clog2(`CLAW_TICK_CYCLES);

    rope_state_t       state;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              dir_cw;
    logic              carrying;
    logic              slow_phase;
    logic              rel_wait;

    assign tick    = (tick_cnt == TICK_W'(`CLAW_TICK_CYCLES - 1));
    assign holding = carrying;

    // frame counter stands still while a scan or a release is pending
    always_ff @(posedge clock) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (state != wait_scan && !rel_wait) begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= stop;
            angle       <= 8'd90;
            rope_len    <= rope_len_t'(`CLAW_ROPE_MIN);
            dir_cw      <= 1'b0;
            carrying    <= 1'b0;
            slow_phase  <= 1'b0;
            rel_wait    <= 1'b0;
            step_valid  <= 1'b0;
            release_req <= 1'b0;
        end else begin
            step_valid  <= 1'b0;
            release_req <= 1'b0;
            case (state)
                stop: begin
                    if (tick) begin
                        state <= swing_ccw;
                    end
                end
                swing_ccw: begin
                    if (tick && go) begin
                        dir_cw <= 1'b0;
                        state  <= extend;
                    end else if (tick) begin
                        angle <= angle - 8'd1;
                        if (angle <= 8'd16) begin
                            state <= swing_cw;
                        end
                    end
                end
                swing_cw: begin
                    if (tick && go) begin
                        dir_cw <= 1'b1;
                        state  <= extend;
                    end else if (tick) begin
                        angle <= angle + 8'd1;
                        if (angle >= 8'd164) begin
                            state <= swing_ccw;
                        end
                    end
                end
                extend: begin
                    if (tick) begin
                        rope_len   <= rope_len + rope_len_t'(`CLAW_STEP);
                        step_valid <= 1'b1;
                        state      <= wait_scan;
                    end
                end
                // release_done next to scan_done means the tip left the screen
                wait_scan: begin
                    if (scan_done) begin
                        if (hit || release_done ||
                                rope_len > rope_len_t'(`CLAW_ROPE_MAX - `CLAW_STEP)) begin
                            carrying   <= hit;
                            slow_phase <= 1'b0;
                            state      <= retract;
                        end else begin
                            state <= extend;
                        end
                    end
                end
                retract: begin
                    if (rel_wait) begin
                        if (release_done) begin
                            rel_wait <= 1'b0;
                            carrying <= 1'b0;
                            state    <= dir_cw ? swing_cw : swing_ccw;
                        end
                    end else if (tick) begin
                        slow_phase <= ~slow_phase;
                        // a loaded rope only moves on every second tick
                        if (!carrying || slow_phase) begin
                            if (rope_len <= rope_len_t'(`CLAW_ROPE_MIN + `CLAW_STEP)) begin
                                rope_len <= rope_len_t'(`CLAW_ROPE_MIN);
                                if (carrying) begin
                                    release_req <= 1'b1;
                                    rel_wait    <= 1'b1;
                                end else begin
                                    state <= dir_cw ? swing_cw : swing_ccw;
                                end
                            end else begin
                                rope_len <= rope_len - rope_len_t'(`CLAW_STEP);
                            end
                        end
                    end
                end
                default: state <= stop;
            endcase
        end
    end

    a_angle_range: assert property (@(posedge clock) disable iff (!resetn)
        angle >= 8'd15 && angle <= 8'd165);

    a_len_range: assert property (@(posedge clock) disable iff (!resetn)
        rope_len >= rope_len_t'(`CLAW_ROPE_MIN) && rope_len <= rope_len_t'(`CLAW_ROPE_MAX));

endmodule

// ==== rtl/tip_position.sv ====
`timescale 1ns/1ps
`include "claw_cfg.svh"

module tip_position (
    input  logic                     clock,
    input  logic                     resetn,
    input  claw_geom_pkg::rope_len_t rope_len,
    input  claw_geom_pkg::angle_t    angle,
    input  logic                     step_valid,
    output claw_geom_pkg::coord_t    tip_x,
    output claw_geom_pkg::coord_t    tip_y,
    output logic                     tip_valid,
    output logic                     off_screen
);

    localparam logic signed [12:0] ORG_X = 13'(`CLAW_ORIGIN_X);
    localparam logic signed [12:0] ORG_Y = 13'(`CLAW_ORIGIN_Y);
    localparam logic signed [12:0] EDGE_X = 13'(`CLAW_SCREEN_W - 2);
    localparam logic signed [12:0] EDGE_Y = 13'(`CLAW_SCREEN_H - 2);

    logic [8:0]         sin_q;
    logic [8:0]         cos_q;
    logic               cos_neg;
    logic [17:0]        dx_full;
    logic [17:0]        dy_full;
    logic signed [12:0] dx;
    logic signed [12:0] dy;
    logic signed [12:0] x_calc;
    logic signed [12:0] y_calc;

    trig_table u_trig_table (
        .angle   (angle),
        .sin_q   (sin_q),
        .cos_q   (cos_q),
        .cos_neg (cos_neg)
    );

    // length times 8-bit fraction, scaled back to pixels
    assign dx_full = rope_len * cos_q;
    assign dy_full = rope_len * sin_q;
    assign dx      = $signed({3'b000, dx_full[17:8]});
    assign dy      = $signed({3'b000, dy_full[17:8]});
    assign x_calc  = cos_neg ? ORG_X - dx : ORG_X + dx;
    assign y_calc  = ORG_Y + dy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            tip_valid <= 1'b0;
        end else begin
            tip_valid <= step_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (step_valid) begin
            tip_x      <= x_calc[9:0];
            tip_y      <= y_calc[9:0];
            off_screen <= x_calc < 13'sd2 || x_calc >= EDGE_X || y_calc >= EDGE_Y;
        end
    end

endmodule

// ==== rtl/item_scanner.sv ====
`timescale 1ns/1ps
`include "claw_cfg.svh"

module item_scanner (
    input  logic                       clock,
    input  logic                       resetn,
    input  claw_geom_pkg::coord_t      tip_x,
    input  claw_geom_pkg::coord_t      tip_y,
    input  logic                       tip_valid,
    input  logic                       off_screen,
    input  logic                       release_req,
    output logic                       scan_done,
    output logic                       hit,
    output logic                       release_done,
    output claw_item_pkg::item_index_t scan_addr,
    input  claw_item_pkg::item_word_t  scan_rdata,
    output logic                       scan_we,
    output claw_item_pkg::item_word_t  scan_wdata,
    output logic                       scan_busy,
    input  claw_item_pkg::score_t      score,
    output logic                       score_we,
    output claw_item_pkg::score_t      score_next
);

    import claw_item_pkg::*;

    typedef enum logic [2:0] {
        sc_idle,
        sc_read,
        sc_check,
        sc_rel_read,
        sc_rel_write
    } scan_state_t;

    scan_state_t state;
    item_index_t carry_idx;
    logic [10:0] box_x;
    logic [10:0] box_y;
    logic        grab;
    item_word_t  carried_word;
    item_word_t  cleared_word;
    score_t      kind_value;

    // hit box runs 16 pixels right of and below the item corner
    assign box_x = {2'b00, item_x(scan_rdata)};
    assign box_y = {3'b000, item_y(scan_rdata)};
    assign grab  = scan_rdata[ITEM_VISIBLE] && !scan_rdata[ITEM_CARRIED] &&
                   tip_x > box_x && tip_x <= box_x + 11'd16 &&
                   tip_y > box_y && tip_y <= box_y + 11'd16;

    assign scan_busy = (state != sc_idle) || scan_we;

    always_comb begin
        carried_word               = scan_rdata;
        carried_word[ITEM_CARRIED] = 1'b1;
        cleared_word               = scan_rdata;
        cleared_word[ITEM_VISIBLE] = 1'b0;
        cleared_word[ITEM_CARRIED] = 1'b0;
        case (item_kind(scan_rdata))
            stone:   kind_value = score_t'(`CLAW_SCORE_STONE);
            gold:    kind_value = score_t'(`CLAW_SCORE_GOLD);
            diamond: kind_value = score_t'(`CLAW_SCORE_DIAMOND);
            default: kind_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state        <= sc_idle;
            scan_addr    <= '0;
            carry_idx    <= '0;
            scan_done    <= 1'b0;
            hit          <= 1'b0;
            release_done <= 1'b0;
            scan_we      <= 1'b0;
            score_we     <= 1'b0;
        end else begin
            scan_done    <= 1'b0;
            hit          <= 1'b0;
            release_done <= 1'b0;
            scan_we      <= 1'b0;
            score_we     <= 1'b0;
            case (state)
                sc_idle: begin
                    if (release_req) begin
                        scan_addr <= carry_idx;
                        state     <= sc_rel_read;
                    end else if (tip_valid && off_screen) begin
                        // nothing to test, send the rope back empty
                        scan_done    <= 1'b1;
                        release_done <= 1'b1;
                    end else if (tip_valid) begin
                        scan_addr <= '0;
                        state     <= sc_read;
                    end
                end
                sc_read: begin
                    state <= sc_check;
                end
                sc_check: begin
                    if (grab) begin
                        scan_we    <= 1'b1;
                        scan_wdata <= carried_word;
                        carry_idx  <= scan_addr;
                        scan_done  <= 1'b1;
                        hit        <= 1'b1;
                        state      <= sc_idle;
                    end else if (scan_addr == item_index_t'(`CLAW_ITEMS - 1)) begin
                        scan_done <= 1'b1;
                        state     <= sc_idle;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= sc_read;
                    end
                end
                sc_rel_read: begin
                    state <= sc_rel_write;
                end
                // drop the item and bank its value
                sc_rel_write: begin
                    scan_we      <= 1'b1;
                    scan_wdata   <= cleared_word;
                    score_we     <= 1'b1;
                    score_next   <= score + kind_value;
                    release_done <= 1'b1;
                    state        <= sc_idle;
                end
                default: state <= sc_idle;
            endcase
        end
    end

    // longest scan is 33 cycles, so a long quiet stretch means no table writes
    a_we_source: assert property (@(posedge clock) disable iff (!resetn)
        (!tip_valid && !release_req) [*40] |-> !scan_we);

endmodule

// ==== rtl/item_table_apb.sv ====
`timescale 1ns/1ps
`include "claw_cfg.svh"

module item_table_apb (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [4:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    input  claw_item_pkg::item_index_t scan_addr,
    input  logic                       scan_we,
    input  claw_item_pkg::item_word_t  scan_wdata,
    input  logic                       scan_busy,
    output claw_item_pkg::item_word_t  scan_rdata,
    output claw_item_pkg::score_t      score,
    input  logic                       score_we,
    input  claw_item_pkg::score_t      score_next
);

    import claw_item_pkg::*;

    item_word_t mem [`CLAW_ITEMS];
    logic       access;
    logic       wr_done;

    assign access  = psel && penable;
    assign wr_done = access && pready && pwrite;

    // one wait cycle, writes also sit out a busy scanner
    always_ff @(posedge clock) begin
        if (!resetn) begin
            pready <= 1'b0;
        end else begin
            pready <= access && !pready && (!pwrite || !scan_busy);
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < `CLAW_ITEMS; i++) begin
                mem[i] <= '0;
            end
        end else if (scan_we) begin
            mem[scan_addr] <= scan_wdata;
        end else if (wr_done && !paddr[4]) begin
            mem[paddr[3:0]] <= pwdata;
        end
    end

    // score at word 16, bit 0 of a write clears it
    always_ff @(posedge clock) begin
        if (!resetn) begin
            score <= '0;
        end else if (score_we) begin
            score <= score_next;
        end else if (wr_done && paddr[4] && pwdata[0]) begin
            score <= '0;
        end
    end

    always_ff @(posedge clock) begin
        scan_rdata <= mem[scan_addr];
        prdata     <= paddr[4] ? {16'h0000, score} : mem[paddr[3:0]];
    end

    a_ready_in_access: assert property (@(posedge clock) disable iff (!resetn)
        $rose(pready) |-> access);

endmodule

// ==== rtl/claw_top.sv ====
`timescale 1ns/1ps

module claw_top (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [4:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    input  logic                     go,
    output claw_geom_pkg::angle_t    angle,
    output claw_geom_pkg::rope_len_t rope_len,
    output claw_geom_pkg::coord_t    tip_x,
    output claw_geom_pkg::coord_t    tip_y,
    output logic                     tip_valid,
    output logic                     holding
);

    import claw_item_pkg::*;

    logic        step_valid;
    logic        off_screen;
    logic        scan_done;
    logic        hit;
    logic        release_req;
    logic        release_done;
    item_index_t scan_addr;
    item_word_t  scan_rdata;
    logic        scan_we;
    item_word_t  scan_wdata;
    logic        scan_busy;
    score_t      score;
    logic        score_we;
    score_t      score_next;

    rope_fsm u_rope_fsm (
        .clock, .resetn, .go,
        .scan_done, .hit, .release_done,
        .angle, .rope_len, .step_valid, .release_req, .holding
    );

    tip_position u_tip_position (
        .clock, .resetn,
        .rope_len, .angle, .step_valid,
        .tip_x, .tip_y, .tip_valid, .off_screen
    );

    item_scanner u_item_scanner (
        .clock, .resetn,
        .tip_x, .tip_y, .tip_valid, .off_screen, .release_req,
        .scan_done, .hit, .release_done,
        .scan_addr, .scan_rdata, .scan_we, .scan_wdata, .scan_busy,
        .score, .score_we, .score_next
    );

    item_table_apb u_item_table_apb (
        .clock, .resetn,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .scan_addr, .scan_we, .scan_wdata, .scan_busy, .scan_rdata,
        .score, .score_we, .score_next
    );

endmodule

// ==== bench/tb_claw.sv ====
`timescale 1ns/1ps
`include "claw_cfg.svh"

module tb_claw;

    localparam int THROWS = 8;
    // a full sweep, the throw and a loaded return, per throw
    localparam int LIMIT = THROWS * 420 * `CLAW_TICK_CYCLES + 40 * `CLAW_ITEMS + 2000;

    logic        clock = 1'b0;
    logic        resetn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic        go;
    logic        tip_valid;
    logic        holding;
    logic        pready;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic [31:0] rd;
    logic [31:0] model [16];
    logic [7:0]  angle;
    logic [7:0]  prev_angle;
    logic [8:0]  rope_len;
    logic [8:0]  prev_len;
    logic [9:0]  tip_x;
    logic [9:0]  tip_y;
    logic [15:0] model_score;
    logic        pend_hit;
    logic        got_hold;
    logic        hold_d;
    int          pend_idx;
    int          cycles = 0;

    claw_top u_claw_top (.*);

    always #20 clock = ~clock;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            stop_with_error("timeout: the run did not finish within the cycle limit");
        end
    end

    function automatic logic [15:0] kind_points(input logic [1:0] kind);
        return kind == 2'd0 ? 16'd`CLAW_SCORE_STONE :
               kind == 2'd1 ? 16'd`CLAW_SCORE_GOLD : 16'd`CLAW_SCORE_DIAMOND;
    endfunction

    function automatic logic in_box(input logic [31:0] w, input int x, input int y);
        return w[19] && x > int'(w[8:0]) && x <= int'(w[8:0]) + 16 &&
               y > int'(w[16:9]) && y <= int'(w[16:9]) + 16;
    endfunction

    // below the pivot, no farther than the rope, on the side it leans to
    function automatic logic tip_in_reach(input int ang, input int len, input int x, input int y);
        int dx;
        dx = x - `CLAW_ORIGIN_X;
        return y >= `CLAW_ORIGIN_Y && y <= `CLAW_ORIGIN_Y + len &&
               dx >= -len && dx <= len &&
               (ang > 90 || dx >= 0) && (ang < 90 || dx <= 0);
    endfunction

    // hit prediction from the table model, lowest index wins
    always @(posedge clock) begin
        prev_angle <= angle;
        prev_len   <= rope_len;
        if (!resetn) begin
            pend_hit <= 1'b0;
            got_hold <= 1'b0;
            hold_d   <= 1'b0;
            pend_idx <= 0;
        end else begin
            hold_d <= holding;
            if (holding) begin
                got_hold <= 1'b1;
            end
            if (tip_valid) begin
                pend_hit <= 1'b0;
                got_hold <= 1'b0;
                for (int i = 15; i >= 0; i--) begin
                    if (in_box(model[i], int'(tip_x), int'(tip_y))) begin
                        pend_hit <= 1'b1;
                        pend_idx <= i;
                    end
                end
            end
            // carried item dropped and banked
            if (hold_d && !holding) begin
                model[pend_idx][20:19] <= 2'b00;
                model_score <= model_score + kind_points(model[pend_idx][18:17]);
            end
        end
    end

    a_angle_range: assert property (@(posedge clock) disable iff (!resetn)
        angle >= 8'd15 && angle <= 8'd165)
        else stop_with_error($sformatf("** Error at %0t: angle expected 15..165, got %0d",
            $time, angle));
    a_angle_step: assert property (@(posedge clock) disable iff (!resetn)
        angle != prev_angle |-> angle == prev_angle + 8'd1 || angle == prev_angle - 8'd1)
        else stop_with_error($sformatf("** Error at %0t: angle expected %0d +/- 1, got %0d",
            $time, prev_angle, angle));
    a_len_max: assert property (@(posedge clock) disable iff (!resetn)
        rope_len <= 9'd`CLAW_ROPE_MAX)
        else stop_with_error($sformatf("** Error at %0t: rope_len expected <= %0d, got %0d",
            $time, `CLAW_ROPE_MAX, rope_len));
    a_len_step: assert property (@(posedge clock) disable iff (!resetn)
        rope_len > prev_len |-> rope_len == prev_len + 9'd`CLAW_STEP)
        else stop_with_error($sformatf("** Error at %0t: rope_len expected %0d, got %0d",
            $time, prev_len + `CLAW_STEP, rope_len));
    // straight down the tip sits right under the pivot
    a_tip_down: assert property (@(posedge clock) disable iff (!resetn)
        tip_valid && angle == 8'd90 |->
            tip_x == 10'd`CLAW_ORIGIN_X && tip_y == 10'(`CLAW_ORIGIN_Y + rope_len))
        else stop_with_error($sformatf("** Error at %0t: tip_x/tip_y expected %0d/%0d, got %0d/%0d",
            $time, `CLAW_ORIGIN_X, `CLAW_ORIGIN_Y + rope_len, tip_x, tip_y));
    a_tip_reach: assert property (@(posedge clock) disable iff (!resetn)
        tip_valid |-> tip_in_reach(int'(angle), int'(rope_len), int'(tip_x), int'(tip_y)))
        else stop_with_error($sformatf(
            "** Error at %0t: tip_x/tip_y expected within %0d of the pivot, got %0d/%0d",
            $time, rope_len, tip_x, tip_y));
    a_hold_only_on_hit: assert property (@(posedge clock) disable iff (!resetn)
        $rose(holding) |-> pend_hit)
        else stop_with_error($sformatf("** Error at %0t: holding expected 0, got %b",
            $time, holding));
    a_hit_grabbed: assert property (@(posedge clock) disable iff (!resetn)
        tip_valid && pend_hit |-> got_hold)
        else stop_with_error($sformatf("** Error at %0t: holding expected 1, got 0", $time));

    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] data);
        @(posedge clock);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clock);
        #2;
        penable = 1'b1;
        do begin
            @(posedge clock);
            #2;
        end while (!pready);
        rd = prdata;
        @(posedge clock);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_read(input logic [4:0] addr, input logic [31:0] exp, input string name);
        apb_xfer(1'b0, addr, 32'h0);
        assert (rd === exp)
            else stop_with_error($sformatf("** Error at %0t: %s expected %h, got %h",
                $time, name, exp, rd));
    endtask

    task automatic write_item(input int idx, input int x, input int y, input logic vis);
        logic [31:0] w;
        w = {12'd0, vis, 2'($urandom % 3), 8'(y), 9'(x)};
        model[idx] = w;
        apb_xfer(1'b1, 5'(idx), w);
    endtask

    task automatic wait_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic throw_rope(input logic [7:0] target, input logic write_mid);
        do begin
            wait_cycle();
        end while (angle != target || holding || rope_len != 9'd`CLAW_ROPE_MIN);
        go = 1'b1;
        do begin
            wait_cycle();
        end while (rope_len == 9'd`CLAW_ROPE_MIN);
        go = 1'b0;
        if (write_mid) begin
            // table write lands on a running scan
            do begin
                wait_cycle();
            end while (!tip_valid);
            write_item(15, 300, 20, 1'b0);
            check_read(5'd15, model[15], "item 15");
        end
        do begin
            wait_cycle();
        end while (rope_len != 9'd`CLAW_ROPE_MIN || holding);
        wait_cycle();
        check_read(5'd16, {16'h0, model_score}, "score");
        check_read(5'(pend_idx), model[pend_idx], $sformatf("item %0d", pend_idx));
    endtask

    initial begin
        void'($urandom(74809));
        resetn      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        go          = 1'b0;
        model_score = '0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clock);
        #2;
        resetn = 1'b1;
        for (int i = 0; i <= 16; i++) begin
            check_read(5'(i), 32'h0, $sformatf("word %0d", i));
        end
        // a column under the pivot, then scattered items
        for (int i = 0; i < 5; i++) begin
            write_item(i, 150, 60 + 20 * i, 1'b1);
        end
        for (int i = 5; i < 15; i++) begin
            write_item(i, 20 + $urandom % 260, 60 + $urandom % 140, 1'b1);
        end
        write_item(15, 300, 20, 1'b0);
        for (int i = 0; i < 16; i++) begin
            check_read(5'(i), model[i], $sformatf("item %0d", i));
        end
        for (int t = 0; t < THROWS; t++) begin
            throw_rope(t < 2 ? 8'd90 : 8'(70 + $urandom % 41), t == 2);
        end
        apb_xfer(1'b1, 5'd16, 32'h1);
        model_score = '0;
        check_read(5'd16, 32'h0, "score");
        $display("sim passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/claw_geom_pkg.sv
rtl/claw_item_pkg.sv
rtl/trig_table.sv
rtl/rope_fsm.sv
rtl/tip_position.sv
rtl/item_scanner.sv
rtl/item_table_apb.sv
rtl/claw_top.sv
bench/tb_claw.sv

// ==== run.sh ====
#!/bin/sh
# build and run the claw testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_claw -o sim_claw
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_claw > sim.log 2>&1
status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
